/* logic/icache_pkg.sv */
// Address, data and index types, CPU and memory channel structs, controller state encoding
package icache_pkg;

  //////////////////////////////////////////////////
  // Geometry
  //////////////////////////////////////////////////

  localparam int unsigned PhysAddrLen    = 32;
  localparam int unsigned LineOffsetBits = 6;
  localparam int unsigned BeatsPerLine   = 8;

  //////////////////////////////////////////////////
  // Widths with a meaning
  //////////////////////////////////////////////////

  typedef logic [PhysAddrLen-1:0]                phys_addr_t;
  typedef logic [PhysAddrLen-LineOffsetBits-1:0] line_addr_t;
  typedef logic [63:0]                           beat_data_t;
  typedef logic [31:0]                           instr_t;
  typedef logic [$clog2(BeatsPerLine)-1:0]       beat_idx_t;

  // CPU fetch request, flush set means invalidate everything
  typedef struct packed {
    phys_addr_t addr;
    logic       flush;
  } fetch_req_t;

  // Line request towards memory
  typedef struct packed {
    line_addr_t line_addr;
  } mem_req_t;

  // One refill beat from memory
  typedef struct packed {
    beat_data_t data;
  } mem_gnt_t;

  typedef enum logic [2:0] {
    StateSweep,
    StateIdle,
    StateLookup,
    StateRequest,
    StateFill,
    StateReplay,
    StateAnswer
  } ctrl_state_e;

endpackage

/* logic/line_index_counter.sv */
// Shared beat and set counter with last flag, plus the pseudo-FIFO victim pointer
module line_index_counter #(
  parameter  int unsigned WaysWidth = 2,
  parameter  int unsigned SetsWidth = 6,
  localparam int unsigned IdxWidth  = (SetsWidth > 3) ? SetsWidth : 3
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 clear_i,
  input  logic                 step_i,
  input  logic                 sweep_i,
  input  logic                 miss_i,
  output logic [IdxWidth-1:0]  index_o,
  output logic                 last_o,
  output logic [WaysWidth-1:0] victim_o
);

  localparam logic [IdxWidth-1:0] LastBeat = IdxWidth'(icache_pkg::BeatsPerLine - 1);
  localparam logic [IdxWidth-1:0] LastSet  = IdxWidth'((2 ** SetsWidth) - 1);

  logic [IdxWidth-1:0]  index_q;
  logic [WaysWidth-1:0] victim_q;

  //////////////////////////////////////////////////
  // Index counter
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      index_q <= '0;
    end else if (clear_i) begin
      index_q <= '0;
    end else if (step_i) begin
      index_q <= index_q + 1'b1;
    end
  end

  // Sweep counts sets, otherwise beats of a line
  assign last_o  = sweep_i ? (index_q == LastSet) : (index_q == LastBeat);
  assign index_o = index_q;

  //////////////////////////////////////////////////
  // Victim pointer
  //////////////////////////////////////////////////

  // Wraps naturally modulo the number of ways
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      victim_q <= '0;
    end else if (miss_i) begin
      victim_q <= victim_q + 1'b1;
    end
  end

  assign victim_o = victim_q;

  // Controller leaves the counting state on the final count
  a_no_step_past_last: assert property (@(posedge clk_i) disable iff (!rst_ni)
      step_i && last_o |=> !step_i)
    else $error("counter stepped past its last count");

endmodule

/* logic/tag_array.sv */
// Per-way tag and valid storage with hit compare and victim way selection
module tag_array #(
  parameter int unsigned WaysWidth = 2,
  parameter int unsigned SetsWidth = 6
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   rd_en_i,
  input  icache_pkg::phys_addr_t rd_addr_i,
  input  logic                   we_i,
  input  logic                   wr_valid_i,
  input  logic [SetsWidth-1:0]   wr_set_i,
  input  logic                   sweep_i,
  input  logic [WaysWidth-1:0]   victim_i,
  output logic                   hit_o,
  output logic [WaysWidth-1:0]   way_o
);

  localparam int unsigned NumWays  = 2 ** WaysWidth;
  localparam int unsigned NumSets  = 2 ** SetsWidth;
  localparam int unsigned TagWidth =
      icache_pkg::PhysAddrLen - icache_pkg::LineOffsetBits - SetsWidth;

  typedef struct packed {
    logic                valid;
    logic [TagWidth-1:0] tag;
  } tag_entry_t;

  tag_entry_t             tag_mem [NumWays][NumSets];
  tag_entry_t             rd_q    [NumWays];
  icache_pkg::phys_addr_t addr_q;
  tag_entry_t             wr_entry;
  logic [NumWays-1:0]     hit_vec;
  logic                   rd_done_q;

  // Refill tag comes from the address of the last read
  assign wr_entry.valid = wr_valid_i;
  assign wr_entry.tag   = addr_q[icache_pkg::PhysAddrLen-1 -: TagWidth];

  //////////////////////////////////////////////////
  // Storage with synchronous read
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    for (int w = 0; w < NumWays; w++) begin
      // Sweep clears every way of the set
      if (we_i && (sweep_i || way_o == WaysWidth'(w))) begin
        tag_mem[w][wr_set_i] <= wr_entry;
      end
      if (rd_en_i) begin
        rd_q[w] <= tag_mem[w][rd_addr_i[icache_pkg::LineOffsetBits +: SetsWidth]];
      end
    end
    if (rd_en_i) begin
      addr_q <= rd_addr_i;
    end
  end

  //////////////////////////////////////////////////
  // Hit compare and way choice
  //////////////////////////////////////////////////

  always_comb begin
    hit_vec = '0;
    for (int w = 0; w < NumWays; w++) begin
      hit_vec[w] = rd_q[w].valid && (rd_q[w].tag == wr_entry.tag);
    end

    // Victim unless an empty way exists, lowest hit wins over both
    way_o = victim_i;
    for (int w = NumWays - 1; w >= 0; w--) begin
      if (!rd_q[w].valid) begin
        way_o = WaysWidth'(w);
      end
    end
    for (int w = NumWays - 1; w >= 0; w--) begin
      if (hit_vec[w]) begin
        way_o = WaysWidth'(w);
      end
    end
  end

  assign hit_o = |hit_vec;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_done_q <= 1'b0;
    end else if (rd_en_i) begin
      rd_done_q <= 1'b1;
    end
  end

  // Refill only installs a line that missed, so no duplicates
  a_single_hit: assert property (@(posedge clk_i) disable iff (!rst_ni)
      rd_done_q |-> $onehot0(hit_vec))
    else $error("more than one way hits");

endmodule

/* logic/data_array.sv */
// Per-way beat storage with synchronous read and word select for the response
module data_array #(
  parameter int unsigned WaysWidth = 2,
  parameter int unsigned SetsWidth = 6
) (
  input  logic                   clk_i,
  input  logic                   we_i,
  input  logic [WaysWidth-1:0]   way_i,
  input  logic [SetsWidth-1:0]   wr_set_i,
  input  icache_pkg::beat_idx_t  wr_beat_i,
  input  icache_pkg::beat_data_t wr_data_i,
  input  logic                   rd_en_i,
  input  icache_pkg::phys_addr_t rd_addr_i,
  output icache_pkg::instr_t     instr_o
);

  localparam int unsigned NumWays  = 2 ** WaysWidth;
  localparam int unsigned AddrBits = SetsWidth + $bits(icache_pkg::beat_idx_t);

  icache_pkg::beat_data_t data_mem [NumWays][2 ** AddrBits];
  icache_pkg::beat_data_t rd_q     [NumWays];
  icache_pkg::beat_data_t rd_beat;
  logic                   upper_q;

  // One row per beat, set in the upper address bits
  always_ff @(posedge clk_i) begin
    for (int w = 0; w < NumWays; w++) begin
      if (we_i && way_i == WaysWidth'(w)) begin
        data_mem[w][{wr_set_i, wr_beat_i}] <= wr_data_i;
      end
      if (rd_en_i) begin
        rd_q[w] <= data_mem[w][rd_addr_i[3 +: AddrBits]];
      end
    end
    if (rd_en_i) begin
      upper_q <= rd_addr_i[2];
    end
  end

  // Way comes from the tag compare of the same read
  assign rd_beat = rd_q[way_i];
  assign instr_o = upper_q ? rd_beat[63:32] : rd_beat[31:0];

endmodule

/* logic/fetch_ctrl.sv */
// Cache controller FSM for lookup, miss request, refill, replay and invalidation sweep
module fetch_ctrl #(
  parameter  int unsigned SetsWidth = 6,
  localparam int unsigned IdxWidth  = (SetsWidth > 3) ? SetsWidth : 3
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   req_valid_i,
  input  icache_pkg::fetch_req_t req_i,
  output logic                   resp_valid_o,
  output logic                   flush_done_o,
  output logic                   mem_req_valid_o,
  output icache_pkg::mem_req_t   mem_req_o,
  input  logic                   mem_req_ready_i,
  input  logic                   mem_gnt_valid_i,
  output logic                   mem_gnt_ready_o,
  output logic                   cnt_clear_o,
  output logic                   cnt_step_o,
  output logic                   cnt_sweep_o,
  input  logic [IdxWidth-1:0]    cnt_index_i,
  input  logic                   cnt_last_i,
  output logic                   rd_en_o,
  output icache_pkg::phys_addr_t rd_addr_o,
  output logic                   tag_we_o,
  output logic                   tag_valid_o,
  output logic                   data_we_o,
  output logic [SetsWidth-1:0]   wr_set_o,
  output icache_pkg::beat_idx_t  wr_beat_o,
  input  logic                   hit_i
);

  icache_pkg::ctrl_state_e state_q, state_d;
  icache_pkg::fetch_req_t  req_q;

  //////////////////////////////////////////////////
  // Next state and control strobes
  //////////////////////////////////////////////////

  always_comb begin
    state_d         = state_q;
    cnt_clear_o     = 1'b0;
    cnt_step_o      = 1'b0;
    rd_en_o         = 1'b0;
    tag_we_o        = 1'b0;
    tag_valid_o     = 1'b0;
    data_we_o       = 1'b0;
    resp_valid_o    = 1'b0;
    flush_done_o    = 1'b0;
    mem_req_valid_o = 1'b0;
    mem_gnt_ready_o = 1'b0;

    unique case (state_q)
      // Invalidate one set per cycle, all ways at once
      icache_pkg::StateSweep: begin
        tag_we_o   = 1'b1;
        cnt_step_o = 1'b1;
        if (cnt_last_i) begin
          // Only a requested flush is acknowledged
          flush_done_o = req_q.flush;
          state_d      = icache_pkg::StateIdle;
        end
      end
      icache_pkg::StateIdle: begin
        if (req_valid_i) begin
          if (req_i.flush) begin
            cnt_clear_o = 1'b1;
            state_d     = icache_pkg::StateSweep;
          end else begin
            state_d = icache_pkg::StateLookup;
          end
        end
      end
      icache_pkg::StateLookup, icache_pkg::StateReplay: begin
        rd_en_o = 1'b1;
        state_d = icache_pkg::StateAnswer;
      end
      icache_pkg::StateAnswer: begin
        if (hit_i) begin
          resp_valid_o = 1'b1;
          state_d      = icache_pkg::StateIdle;
        end else begin
          // Beat index starts from zero for the refill
          cnt_clear_o = 1'b1;
          state_d     = icache_pkg::StateRequest;
        end
      end
      icache_pkg::StateRequest: begin
        mem_req_valid_o = 1'b1;
        if (mem_req_ready_i) begin
          state_d = icache_pkg::StateFill;
        end
      end
      icache_pkg::StateFill: begin
        mem_gnt_ready_o = 1'b1;
        if (mem_gnt_valid_i) begin
          data_we_o  = 1'b1;
          cnt_step_o = 1'b1;
          // Tag goes valid together with the last beat
          if (cnt_last_i) begin
            tag_we_o    = 1'b1;
            tag_valid_o = 1'b1;
            state_d     = icache_pkg::StateReplay;
          end
        end
      end
      default: state_d = icache_pkg::StateIdle;
    endcase
  end

  assign cnt_sweep_o = (state_q == icache_pkg::StateSweep);
  assign rd_addr_o   = req_q.addr;
  assign mem_req_o.line_addr =
      req_q.addr[icache_pkg::PhysAddrLen-1:icache_pkg::LineOffsetBits];

  // Sweep walks the counter, a refill writes the set of the fetch address
  assign wr_set_o  = cnt_sweep_o ? cnt_index_i[SetsWidth-1:0]
                                 : req_q.addr[icache_pkg::LineOffsetBits +: SetsWidth];
  assign wr_beat_o = cnt_index_i[$bits(icache_pkg::beat_idx_t)-1:0];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= icache_pkg::StateSweep;
      req_q   <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == icache_pkg::StateIdle && req_valid_i) begin
        req_q <= req_i;
      end
    end
  end

  //////////////////////////////////////////////////
  // Protocol checks
  //////////////////////////////////////////////////

  // Line request is held unchanged until memory takes it
  a_req_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
      mem_req_valid_o && !mem_req_ready_i |=> mem_req_valid_o && $stable(mem_req_o))
    else $error("mem_req_o changed while waiting for ready");

  // CPU must wait for the response or the flush-done pulse
  a_req_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
      req_valid_i |-> state_q == icache_pkg::StateIdle)
    else $error("CPU request outside idle");

endmodule

/* logic/icache_top.sv */
// Instruction cache top level with controller, index counter, tag array and data array
module icache_top #(
  parameter int unsigned WaysWidth = 2,
  parameter int unsigned SetsWidth = 6
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // CPU side
  input  logic                   req_valid_i,
  input  icache_pkg::fetch_req_t req_i,
  output logic                   resp_valid_o,
  output icache_pkg::instr_t     resp_instr_o,
  output logic                   flush_done_o,
  // Memory side
  output logic                   mem_req_valid_o,
  output icache_pkg::mem_req_t   mem_req_o,
  input  logic                   mem_req_ready_i,
  input  logic                   mem_gnt_valid_i,
  input  icache_pkg::mem_gnt_t   mem_gnt_i,
  output logic                   mem_gnt_ready_o
);

  localparam int unsigned IdxWidth = (SetsWidth > 3) ? SetsWidth : 3;

  // Set index has to stay inside the 4 KiB page offset
  if (SetsWidth > 6) begin : g_sets_check
    $fatal(1, "SetsWidth is bounded by 6");
  end

  logic                   cnt_clear;
  logic                   cnt_step;
  logic                   cnt_sweep;
  logic [IdxWidth-1:0]    cnt_index;
  logic                   cnt_last;
  logic [WaysWidth-1:0]   victim;
  logic                   rd_en;
  icache_pkg::phys_addr_t rd_addr;
  logic                   tag_we;
  logic                   tag_valid;
  logic                   data_we;
  logic [SetsWidth-1:0]   wr_set;
  icache_pkg::beat_idx_t  wr_beat;
  logic                   hit;
  logic [WaysWidth-1:0]   way;

  fetch_ctrl #(
    .SetsWidth (SetsWidth)
  ) u_fetch_ctrl (
    .clk_i,
    .rst_ni,
    .req_valid_i,
    .req_i,
    .resp_valid_o,
    .flush_done_o,
    .mem_req_valid_o,
    .mem_req_o,
    .mem_req_ready_i,
    .mem_gnt_valid_i,
    .mem_gnt_ready_o,
    .cnt_clear_o (cnt_clear),
    .cnt_step_o  (cnt_step),
    .cnt_sweep_o (cnt_sweep),
    .cnt_index_i (cnt_index),
    .cnt_last_i  (cnt_last),
    .rd_en_o     (rd_en),
    .rd_addr_o   (rd_addr),
    .tag_we_o    (tag_we),
    .tag_valid_o (tag_valid),
    .data_we_o   (data_we),
    .wr_set_o    (wr_set),
    .wr_beat_o   (wr_beat),
    .hit_i       (hit)
  );

  // A valid tag is only written as a refill completes, so it also marks the miss
  line_index_counter #(
    .WaysWidth (WaysWidth),
    .SetsWidth (SetsWidth)
  ) u_line_index_counter (
    .clk_i,
    .rst_ni,
    .clear_i  (cnt_clear),
    .step_i   (cnt_step),
    .sweep_i  (cnt_sweep),
    .miss_i   (tag_valid),
    .index_o  (cnt_index),
    .last_o   (cnt_last),
    .victim_o (victim)
  );

  tag_array #(
    .WaysWidth (WaysWidth),
    .SetsWidth (SetsWidth)
  ) u_tag_array (
    .clk_i,
    .rst_ni,
    .rd_en_i    (rd_en),
    .rd_addr_i  (rd_addr),
    .we_i       (tag_we),
    .wr_valid_i (tag_valid),
    .wr_set_i   (wr_set),
    .sweep_i    (cnt_sweep),
    .victim_i   (victim),
    .hit_o      (hit),
    .way_o      (way)
  );

  data_array #(
    .WaysWidth (WaysWidth),
    .SetsWidth (SetsWidth)
  ) u_data_array (
    .clk_i,
    .we_i      (data_we),
    .way_i     (way),
    .wr_set_i  (wr_set),
    .wr_beat_i (wr_beat),
    .wr_data_i (mem_gnt_i.data),
    .rd_en_i   (rd_en),
    .rd_addr_i (rd_addr),
    .instr_o   (resp_instr_o)
  );

endmodule

/* testbench/line_memory_model.sv */
// Line memory model with random request stalls, random beat gaps and rule-based beat data
module line_memory_model #(
  parameter int                 Seed    = 1,
  parameter icache_pkg::instr_t DataKey = '0
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 req_valid_i,
  input  icache_pkg::mem_req_t req_i,
  output logic                 req_ready_o,
  output logic                 gnt_valid_o,
  output icache_pkg::mem_gnt_t gnt_o,
  input  logic                 gnt_ready_i
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int DriveDelay = 1;

  integer                 seed;
  icache_pkg::line_addr_t line;
  int                     beat;
  logic                   got;

  // Lower word at the beat address, upper word four bytes above
  function automatic icache_pkg::beat_data_t beat_data(icache_pkg::line_addr_t la, int b);
    icache_pkg::phys_addr_t a;
    a = {la, 3'(b), 3'b000};
    return {(a | 32'd4) ^ DataKey, a ^ DataKey};
  endfunction

  initial begin
    seed        = Seed;
    req_ready_o = 1'b0;
    gnt_valid_o = 1'b0;
    gnt_o       = '0;
    wait (rst_ni);
    forever begin
      // Request phase with random ready stalls
      got = 1'b0;
      while (!got) begin
        req_ready_o = (($random(seed) & 1) != 0);
        @(posedge clk_i);
        got = req_valid_i && req_ready_o;
        if (got) begin
          line = req_i.line_addr;
        end
        #DriveDelay;
      end
      req_ready_o = 1'b0;
      // Eight beats in order, with random gaps
      beat = 0;
      while (beat < icache_pkg::BeatsPerLine) begin
        gnt_valid_o = (($random(seed) & 3) != 0);
        gnt_o.data  = beat_data(line, beat);
        @(posedge clk_i);
        if (gnt_valid_o && gnt_ready_i) begin
          beat++;
        end
        #DriveDelay;
      end
      gnt_valid_o = 1'b0;
    end
  end

endmodule

/* testbench/tb_icache.sv */
// Instruction cache testbench with clock, reset, directed and random fetches, checks and watchdog
module tb_icache;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int                 ClkPeriod     = 8;
  localparam int                 DriveDelay    = 1;
  localparam int                 WaysWidth     = 2;
  localparam int                 SetsWidth     = 6;
  localparam int                 NumWays       = 2 ** WaysWidth;
  localparam int                 Seed          = 64390;
  localparam icache_pkg::instr_t DataKey       = 32'h5A5A_0000;
  localparam int                 DirectedOps   = 20;
  localparam int                 RandomFetches = 60;
  localparam int                 CyclesPerOp   = 250;
  localparam int                 WatchdogCycles = (DirectedOps + RandomFetches) * CyclesPerOp;
  localparam icache_pkg::phys_addr_t BaseAddr  = 32'h0000_1000;
  localparam icache_pkg::phys_addr_t SpareAddr = 32'h0002_0040;
  localparam icache_pkg::phys_addr_t EvictAddr = 32'h0010_0140;
  localparam icache_pkg::phys_addr_t RandBase  = 32'h0040_0000;

  logic                   clk = 1'b0;
  logic                   rst_n;
  logic                   req_valid;
  icache_pkg::fetch_req_t req;
  logic                   resp_valid;
  icache_pkg::instr_t     resp_instr;
  logic                   flush_done;
  logic                   mem_req_valid, mem_req_ready, mem_gnt_valid, mem_gnt_ready;
  icache_pkg::mem_req_t   mem_req, held_req;
  icache_pkg::mem_gnt_t   mem_gnt;
  icache_pkg::phys_addr_t exp_addr;
  int                     exp_reqs, reqs_seen, misses;
  int                     beats_due;
  bit                     check_reqs, check_latency, flush_pending;
  int                     value_errors = 0;
  int                     protocol_errors = 0;
  int                     timeouts = 0;
  integer                 seed;

  always #(ClkPeriod / 2) clk = ~clk;

  icache_top #(.WaysWidth(WaysWidth), .SetsWidth(SetsWidth)) dut (
    .clk_i(clk), .rst_ni(rst_n), .req_valid_i(req_valid), .req_i(req),
    .resp_valid_o(resp_valid), .resp_instr_o(resp_instr), .flush_done_o(flush_done),
    .mem_req_valid_o(mem_req_valid), .mem_req_o(mem_req), .mem_req_ready_i(mem_req_ready),
    .mem_gnt_valid_i(mem_gnt_valid), .mem_gnt_i(mem_gnt), .mem_gnt_ready_o(mem_gnt_ready)
  );

  line_memory_model #(.Seed(Seed), .DataKey(DataKey)) u_memory (
    .clk_i(clk), .rst_ni(rst_n), .req_valid_i(mem_req_valid), .req_i(mem_req),
    .req_ready_o(mem_req_ready), .gnt_valid_o(mem_gnt_valid), .gnt_o(mem_gnt),
    .gnt_ready_i(mem_gnt_ready)
  );

  // Word at byte address A is A XOR the key
  function automatic icache_pkg::instr_t expected_word(icache_pkg::phys_addr_t a);
    return {a[31:2], 2'b00} ^ DataKey;
  endfunction

  // Line requests seen since the last CPU request
  always_ff @(posedge clk) begin
    held_req <= mem_req;
    if (req_valid) begin
      reqs_seen <= 0;
    end else if (mem_req_valid && mem_req_ready) begin
      reqs_seen <= reqs_seen + 1;
    end
  end

  // Beats still owed by memory for the line just requested
  always_ff @(posedge clk) begin
    if (mem_req_valid && mem_req_ready) begin
      beats_due <= icache_pkg::BeatsPerLine;
    end else if (mem_gnt_valid && mem_gnt_ready && beats_due > 0) begin
      beats_due <= beats_due - 1;
    end
  end

  ////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////

  a_resp_data: assert property (@(posedge clk) disable iff (!rst_n)
      resp_valid |-> resp_instr == expected_word(exp_addr))
    else begin
      value_errors++;
      $display("[ERROR] %0t resp_instr_o expected %h actual %h", $time,
               expected_word(exp_addr), $sampled(resp_instr));
    end
  a_req_line: assert property (@(posedge clk) disable iff (!rst_n)
      mem_req_valid && mem_req_ready |-> mem_req.line_addr == exp_addr[31:6])
    else begin
      value_errors++;
      $display("[ERROR] %0t mem_req_o expected %h actual %h", $time,
               exp_addr[31:6], $sampled(mem_req.line_addr));
    end
  a_req_count: assert property (@(posedge clk) disable iff (!rst_n)
      resp_valid && check_reqs |-> reqs_seen == exp_reqs)
    else begin
      value_errors++;
      $display("[ERROR] %0t mem_req_valid_o handshakes expected %0d actual %0d", $time,
               exp_reqs, $sampled(reqs_seen));
    end
  a_req_single: assert property (@(posedge clk) disable iff (!rst_n)
      resp_valid |-> reqs_seen <= 1)
    else begin
      protocol_errors++;
      $display("%0t: more than one line request for a single fetch", $time);
    end
  a_hit_latency: assert property (@(posedge clk) disable iff (!rst_n)
      resp_valid && check_latency |-> $past(req_valid, 2))
    else begin
      protocol_errors++;
      $display("%0t: hit response did not come two cycles after its request", $time);
    end
  a_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
      mem_req_valid && !mem_req_ready |=> mem_req == held_req)
    else begin
      value_errors++;
      $display("[ERROR] %0t mem_req_o expected %h actual %h", $time,
               $sampled(held_req), $sampled(mem_req));
    end
  // Ready is high exactly while beats of a requested line are outstanding
  a_gnt_ready: assert property (@(posedge clk) disable iff (!rst_n)
      mem_gnt_ready == (beats_due != 0))
    else begin
      value_errors++;
      $display("[ERROR] %0t mem_gnt_ready_o expected %0b actual %0b", $time,
               ($sampled(beats_due) != 0), $sampled(mem_gnt_ready));
    end
  a_flush_pulse: assert property (@(posedge clk) disable iff (!rst_n)
      flush_done |-> flush_pending)
    else begin
      protocol_errors++;
      $display("%0t: flush_done_o pulsed with no flush pending", $time);
    end

  ////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////

  task automatic await_pulse(input bit flush_wait);
    int cycles;
    cycles = 0;
    while (!(flush_wait ? flush_done : resp_valid) && cycles < CyclesPerOp) begin
      @(posedge clk);
      #DriveDelay;
      cycles++;
    end
    if (!(flush_wait ? flush_done : resp_valid)) begin
      timeouts++;
      $display("%0t: no %s within %0d cycles", $time,
               flush_wait ? "flush done" : "response", CyclesPerOp);
    end
    @(posedge clk);
    #DriveDelay;
  endtask

  // want_reqs below zero leaves hit or miss open
  task automatic fetch(input icache_pkg::phys_addr_t addr, input int want_reqs, input bit timed);
    exp_addr      = addr;
    exp_reqs      = want_reqs;
    check_reqs    = (want_reqs >= 0);
    check_latency = timed;
    if (want_reqs > 0) begin
      misses += want_reqs;
    end
    req_valid  = 1'b1;
    req.addr   = addr;
    req.flush  = 1'b0;
    @(posedge clk);
    #DriveDelay;
    req_valid = 1'b0;
    await_pulse(1'b0);
  endtask

  task automatic flush_all();
    flush_pending = 1'b1;
    req_valid     = 1'b1;
    req.addr      = '0;
    req.flush     = 1'b1;
    @(posedge clk);
    #DriveDelay;
    req_valid = 1'b0;
    await_pulse(1'b1);
    flush_pending = 1'b0;
  endtask

  task automatic report_and_finish(input bit hung);
    $display("Errors: %0d value, %0d protocol, %0d timeouts, watchdog %s",
             value_errors, protocol_errors, timeouts, hung ? "expired" : "idle");
    if (hung || value_errors + protocol_errors + timeouts != 0) begin
      $display("Simulation finished: FAIL");
    end else begin
      $display("Simulation finished: PASS");
    end
    $finish;
  endtask

  initial begin : stimulus
    icache_pkg::phys_addr_t addr;
    int                     spare;
    seed          = Seed;
    rst_n         = 1'b0;
    req_valid     = 1'b0;
    req           = '0;
    exp_addr      = '0;
    exp_reqs      = 0;
    misses        = 0;
    check_reqs    = 1'b0;
    check_latency = 1'b0;
    flush_pending = 1'b0;
    repeat (16) @(posedge clk);
    #DriveDelay;
    rst_n = 1'b1;
    // Reset sweep gives no done pulse, one set per cycle
    repeat ((2 ** SetsWidth) + 2) @(posedge clk);
    #DriveDelay;

    // Miss then hits in the same line, both word halves
    fetch(BaseAddr, 1, 1'b0);
    fetch(BaseAddr + 32'h10, 0, 1'b1);
    fetch(BaseAddr + 32'h24, 0, 1'b1);
    fetch(BaseAddr + 32'h38, 0, 1'b1);
    fetch(BaseAddr + 32'h3C, 0, 1'b1);

    // Misses elsewhere until the victim pointer is back at way 0
    spare = 0;
    while (misses % NumWays != 0) begin
      fetch(SpareAddr + spare * 32'h40, 1, 1'b0);
      spare++;
    end
    for (int k = 0; k <= NumWays; k++) begin
      fetch(EvictAddr + k * 32'h1000, 1, 1'b0);
    end
    fetch(EvictAddr + 32'h4, 1, 1'b0);

    // Cached line has to miss after a flush
    flush_all();
    fetch(BaseAddr + 32'h8, 1, 1'b0);

    for (int n = 0; n < RandomFetches; n++) begin
      addr = RandBase + ($random(seed) & 32'h0000_3FFC);
      fetch(addr, -1, 1'b0);
    end
    report_and_finish(1'b0);
  end

  initial begin : watchdog
    repeat (WatchdogCycles) @(posedge clk);
    $display("Run did not finish within %0d cycles", WatchdogCycles);
    report_and_finish(1'b1);
  end

endmodule

/* build.f */
logic/icache_pkg.sv
logic/line_index_counter.sv
logic/tag_array.sv
logic/data_array.sv
logic/fetch_ctrl.sv
logic/icache_top.sv
testbench/line_memory_model.sv
testbench/tb_icache.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_icache -f build.f

./obj_dir/Vtb_icache | tee sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
  echo "Simulation reported failure"
  exit 1
fi
echo "Simulation reported success"
